/* Makefile */
# Verilator simulation of the protection board
VERILATOR ?= verilator
TOP       ?= prot_tb
FLIST     ?= prot.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* prot.f */
src/prot_bus_pkg.sv
src/prot_game_pkg.sv
src/prot_addr_decode.sv
src/prot_local_ram.sv
src/prot_shared_ram.sv
src/prot_challenge.sv
src/prot_irq_timer.sv
src/prot_read_mux.sv
src/prot_top.sv
sim/prot_tb.sv

/* sim/prot_tb.sv */
// testbench for the protection board with clock, reset, bus tasks, compare tasks and directed tests
`timescale 1ns/1ns

module prot_tb;
    import prot_bus_pkg::*;
    import prot_game_pkg::*;

    logic       clk = 1'b0;
    logic       rst;
    game_id_t   game_id;
    mcu_bus_t   mcu_bus;
    byte_t      mcu_din;
    logic       mcu_waitn;
    logic       mcu_irqn;
    main_addr_t main_addr;
    byte_t      main_dout;
    byte_t      main_din;
    logic       main_cs;
    logic       main_wrn;
    rom_addr_t  rom_addr;
    logic       rom_cs;
    byte_t      rom_data;
    logic       rom_ok;
    bac_req_t   bac_req;
    byte_t      bac_data;
    byte_t      bac_mode_din;
    logic       bac_ok;
    integer     seed;
    int         mismatches;
    int         timeouts;

    prot_top #(.LOCAL_AW(11), .SHARED_AW(13), .IRQ_HOLD(255)) UUT (.*);

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bac(input string name, input bac_req_t got, input bac_req_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    // new controller bus cycle on the rising edge
    task automatic drive_bus(input mcu_addr_t addr, input byte_t dout, input logic wrn,
                             input logic rdn);
        @(posedge clk);
        mcu_bus.addr <= addr;
        mcu_bus.dout <= dout;
        mcu_bus.wrn  <= wrn;
        mcu_bus.rdn  <= rdn;
    endtask

    // controller stalls here until the wait line goes high
    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (mcu_waitn !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (mcu_waitn !== 1'b1) begin
            timeouts++;
            $display("timeout: wait line stuck low during %s", what);
        end
    endtask

    task automatic mcu_write(input mcu_addr_t addr, input byte_t data);
        drive_bus(addr, data, 1'b0, 1'b1);
        // the write lands on this edge and the strobe rises after it
        drive_bus(addr, data, 1'b1, 1'b1);
    endtask

    // data is registered twice so sample on the third falling edge
    task automatic mcu_read(input mcu_addr_t addr, output byte_t data);
        drive_bus(addr, 8'h00, 1'b1, 1'b0);
        repeat (3) @(negedge clk);
        wait_ready("read");
        data = mcu_din;
        drive_bus(21'h0, 8'h00, 1'b1, 1'b1);
    endtask

    // main cpu cycle over two edges while the controller is stalled
    task automatic main_access(input main_addr_t addr, input byte_t data, input logic wrn,
                               output byte_t q);
        @(posedge clk);
        main_cs   <= 1'b1;
        main_wrn  <= wrn;
        main_addr <= addr;
        main_dout <= data;
        @(negedge clk);
        check_bit("mcu_waitn", mcu_waitn, 1'b0);
        @(negedge clk);
        q = main_din;
        @(posedge clk);
        main_cs  <= 1'b0;
        main_wrn <= 1'b1;
    endtask

    task automatic main_write(input main_addr_t addr, input byte_t data);
        byte_t q;
        main_access(addr, data, 1'b0, q);
    endtask

    task automatic main_read(input main_addr_t addr, output byte_t q);
        main_access(addr, 8'h00, 1'b1, q);
    endtask

    task automatic set_game(input game_id_t g);
        @(posedge clk);
        game_id <= g;
    endtask

    // random bytes through the work ram page 1f0000 in both games
    task automatic local_ram_roundtrip();
        mcu_addr_t a;
        byte_t     d;
        byte_t     q;
        for (int g = 0; g < 2; g++) begin
            set_game(game_id_t'(g));
            for (int i = 0; i < 4; i++) begin
                a = 21'h1f0000 | mcu_addr_t'($random(seed) & 32'h7ff);
                d = byte_t'($random(seed));
                mcu_write(a, d);
                mcu_read(a, q);
                check_byte("local ram", q, d);
            end
        end
    endtask

    // main to controller and back away from the interrupt byte at 7ff
    task automatic shared_ram_crossing();
        mcu_addr_t  base;
        main_addr_t a;
        byte_t      d;
        byte_t      q;
        for (int g = 0; g < 2; g++) begin
            set_game(game_id_t'(g));
            // Hippodrome page 18h with bit 13 set stays out of the work ram
            base = (g == 0) ? 21'h1f2000 : 21'h182000;
            a = main_addr_t'($random(seed)) & 11'h3fe;
            d = byte_t'($random(seed));
            main_write(a, d);
            mcu_read(base | mcu_addr_t'(a), q);
            check_byte("mcu shared read", q, d);
            d = ~d;
            mcu_write(base | mcu_addr_t'(a + 11'h400), d);
            main_read(a + 11'h400, q);
            check_byte("main shared read", q, d);
        end
    endtask

    task automatic protection_answers();
        byte_t q;
        byte_t other;
        set_game(GAME_HIPPODROME);
        mcu_write(21'h1d2000, 8'h45);
        mcu_read(21'h1d2000, q);
        check_byte("prot answer 45", q, 8'h4e);
        mcu_write(21'h1d2000, 8'h92);
        mcu_read(21'h1d2000, q);
        check_byte("prot answer 92", q, 8'h15);
        // unknown keys answer zero
        other = byte_t'($random(seed));
        if (other == 8'h45 || other == 8'h92) begin
            other = 8'h01;
        end
        mcu_write(21'h1d2000, other);
        mcu_read(21'h1d2000, q);
        check_byte("prot answer other", q, 8'h00);
        // Robocop maps this page onto the shared ram
        set_game(GAME_ROBOCOP);
        mcu_write(21'h1d2000, 8'h45);
        mcu_read(21'h1d2000, q);
        check_byte("robocop prot page", q, 8'h45);
        // the Robocop write must leave the latch holding the unknown key
        set_game(GAME_HIPPODROME);
        mcu_read(21'h1d2000, q);
        check_byte("latch after robocop write", q, 8'h00);
    endtask

    task automatic rom_and_bac_access();
        rom_addr_t ra;
        mcu_addr_t a;
        byte_t     d;
        byte_t     q;
        bac_req_t  exp;
        ra = rom_addr_t'($random(seed));
        @(posedge clk);
        rom_ok   <= 1'b0;
        rom_data <= byte_t'($random(seed));
        drive_bus(mcu_addr_t'(ra), 8'h00, 1'b1, 1'b0);
        @(negedge clk);
        check_bit("rom_cs", rom_cs, 1'b1);
        check_rom_addr("rom_addr", rom_addr, ra);
        repeat (3) @(negedge clk);
        check_bit("mcu_waitn", mcu_waitn, 1'b0);
        @(posedge clk);
        rom_ok <= 1'b1;
        wait_ready("rom read");
        check_byte("rom read", mcu_din, rom_data);
        drive_bus(21'h0, 8'h00, 1'b1, 1'b1);
        // tile chip window where m 1 is sft and m 2 is map
        set_game(GAME_HIPPODROME);
        for (int m = 1; m < 3; m++) begin
            a = 21'h1a2000 | mcu_addr_t'(m << 11) | mcu_addr_t'($random(seed) & 32'h7ff);
            d = byte_t'($random(seed));
            exp      = '0;
            exp.cs   = 1'b1;
            exp.dsn  = {~a[0], a[0]};
            exp.addr = {m == 2, a[10:1]};
            exp.dout = d;
            drive_bus(a, d, 1'b0, 1'b1);
            @(negedge clk);
            check_bac("bac_req", bac_req, exp);
            drive_bus(a, d, 1'b1, 1'b1);
            mcu_read(a, q);
            check_byte("bac read", q, bac_data);
        end
        // tile chip holds its data back and the controller stalls
        @(posedge clk);
        bac_ok <= 1'b0;
        drive_bus(a, 8'h00, 1'b1, 1'b0);
        repeat (3) @(negedge clk);
        check_bit("mcu_waitn", mcu_waitn, 1'b0);
        @(posedge clk);
        bac_ok <= 1'b1;
        wait_ready("bac read");
        check_byte("bac late read", mcu_din, bac_data);
        drive_bus(21'h0, 8'h00, 1'b1, 1'b1);
        mcu_read(21'h1a2000 | mcu_addr_t'($random(seed) & 32'h7ff), q);
        check_byte("bac mode read", q, bac_mode_din);
        // no tile chip on Robocop so the request stays idle
        set_game(GAME_ROBOCOP);
        drive_bus(21'h1a3000, 8'h5a, 1'b0, 1'b1);
        @(negedge clk);
        exp     = '0;
        exp.rnw = 1'b1;
        exp.dsn = 2'b11;
        check_bac("bac_req idle", bac_req, exp);
        drive_bus(21'h0, 8'h00, 1'b1, 1'b1);
    endtask

    // falling edges until the interrupt line releases
    task automatic measure_irq(input string what);
        int n;
        n = 0;
        while (mcu_irqn === 1'b0 && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (mcu_irqn !== 1'b1) begin
            timeouts++;
            $display("timeout: interrupt never released after %s", what);
        end else if (n < 240 || n > 270) begin
            mismatches++;
            $display("interrupt low for %0d cycles after %s, not within 240 to 270", n, what);
        end
    endtask

    task automatic irq_hold_time();
        byte_t q;
        main_read(11'h7ff, q);
        measure_irq("first access");
        main_read(11'h7ff, q);
        repeat (100) @(negedge clk);
        check_bit("mcu_irqn", mcu_irqn, 1'b0);
        // a second touch mid hold restarts the full count
        main_write(11'h7ff, 8'h3c);
        measure_irq("restart");
    endtask

    initial begin
        seed = 32'h98a491c4;
        mismatches = 0;
        timeouts = 0;
        rst          <= 1'b1;
        game_id      <= GAME_ROBOCOP;
        mcu_bus      <= '{addr: 21'h0, dout: 8'h00, wrn: 1'b1, rdn: 1'b1};
        main_addr    <= '0;
        main_dout    <= '0;
        main_cs      <= 1'b0;
        main_wrn     <= 1'b1;
        rom_data     <= 8'h00;
        rom_ok       <= 1'b1;
        bac_data     <= byte_t'($random(seed));
        bac_mode_din <= byte_t'($random(seed));
        bac_ok       <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // idle bus straight out of reset
        @(negedge clk);
        check_bit("mcu_irqn", mcu_irqn, 1'b1);
        check_byte("mcu_din", mcu_din, 8'hff);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("bac_req.cs", bac_req.cs, 1'b0);
        local_ram_roundtrip();
        shared_ram_crossing();
        protection_answers();
        rom_and_bac_access();
        irq_hold_time();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* src/prot_addr_decode.sv */
// prot_addr_decode: controller memory map per game and tile chip request forming
`timescale 1ns/1ns

module prot_addr_decode (
    input  prot_game_pkg::game_id_t   game_id,
    input  prot_bus_pkg::mcu_bus_t    mcu_bus,
    output prot_bus_pkg::region_sel_t region,
    output prot_bus_pkg::bac_req_t    bac_req
);
    import prot_bus_pkg::*;
    import prot_game_pkg::*;

    // upper five address bits pick the 64 kB page
    logic [4:0] page;
    logic       bac_win;

    assign page = mcu_bus.addr[20:16];

    always_comb begin
        region = '0;
        bac_win = 1'b0;
        // program rom sits in page 0, only on reads
        region.rom = (page == 5'h00) && !mcu_bus.rdn;
        // work ram, 1f0000-1f1fff in Robocop
        // note it also overlaps the upper Hippodrome pages whenever bit 13 is clear
        region.ram = mcu_bus.addr[20] & ~mcu_bus.addr[13];
        case (game_id)
            GAME_HIPPODROME: begin
                region.shd  = (page == 5'h18);
                region.prot = (page == 5'h1d);
                bac_win     = (page == 5'h1a);
                // bits 12..11 split the tile chip window
                region.bac_mode = bac_win && (mcu_bus.addr[12:11] == 2'd0);
                region.bac_sft  = bac_win && (mcu_bus.addr[12:11] == 2'd1);
                region.bac_map  = bac_win && (mcu_bus.addr[12:11] == 2'd2);
            end
            default: begin
                // Robocop shared ram at 1f2000-1f3fff
                region.shd = mcu_bus.addr[20] & mcu_bus.addr[13];
            end
        endcase
    end

    always_comb begin
        // idle request, both byte strobes high
        bac_req      = '0;
        bac_req.rnw  = 1'b1;
        bac_req.dsn  = 2'b11;
        if (game_id == GAME_HIPPODROME) begin
            bac_req.cs   = region.bac_sft | region.bac_map;
            bac_req.rnw  = mcu_bus.wrn;
            bac_req.mode = region.bac_mode;
            // 8-bit bus onto a 16-bit chip, bit 0 picks the byte lane
            bac_req.dsn  = {~mcu_bus.addr[0], mcu_bus.addr[0]};
            // map bit becomes the top of the chip address
            bac_req.addr = {region.bac_map, mcu_bus.addr[10:1]};
            bac_req.dout = mcu_bus.dout;
        end
    end

endmodule

/* src/prot_bus_pkg.sv */
// controller and main bus widths, bus cycle struct, region selects and tile chip request
package prot_bus_pkg;

    // data byte on both buses
    typedef logic [7:0]  byte_t;
    // full controller address, 21 bits
    typedef logic [20:0] mcu_addr_t;
    // main cpu word address into the 2 kB window
    typedef logic [10:0] main_addr_t;
    typedef logic [15:0] rom_addr_t;
    typedef logic [10:0] bac_addr_t;

    // one controller bus cycle, strobes are active low
    typedef struct packed {
        mcu_addr_t addr;
        byte_t     dout;
        logic      wrn;
        logic      rdn;
    } mcu_bus_t;

    // one-hot region selects out of the decoder
    typedef struct packed {
        logic rom;
        logic ram;
        logic shd;
        logic prot;
        logic bac_mode;
        logic bac_sft;
        logic bac_map;
    } region_sel_t;

    // request towards the tile chip (BAC)
    typedef struct packed {
        logic       cs;
        logic       rnw;
        logic       mode;
        logic [1:0] dsn;
        bac_addr_t  addr;
        byte_t      dout;
    } bac_req_t;

endpackage

/* src/prot_challenge.sv */
// prot_challenge: protection latch and its answer lookup
`timescale 1ns/1ns

module prot_challenge (
    input  logic                clk,
    input  logic                rst,
    input  logic                sel,
    input  logic                wrn,
    input  prot_bus_pkg::byte_t data,
    output prot_bus_pkg::byte_t answer
);
    import prot_bus_pkg::*;
    import prot_game_pkg::*;

    // last byte written by the controller
    byte_t key;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= 8'h00;
        end else if (sel && !wrn) begin
            key <= data;
        end
    end

    // only two pairs are known from the game code
    // anything else answers zero
    always_comb begin
        case (key)
            PROT_KEY_A: answer = PROT_ANS_A;
            PROT_KEY_B: answer = PROT_ANS_B;
            default:    answer = 8'h00;
        endcase
    end

endmodule

/* src/prot_game_pkg.sv */
// game id enum, protection key and answer bytes, interrupt timer states
package prot_game_pkg;

    // level input picking the board variant
    typedef enum logic [1:0] {
        GAME_ROBOCOP    = 2'd0,
        GAME_HIPPODROME = 2'd1
    } game_id_t;

    // known challenge pairs seen on Hippodrome
    localparam logic [7:0] PROT_KEY_A = 8'h45;
    localparam logic [7:0] PROT_ANS_A = 8'h4e;
    localparam logic [7:0] PROT_KEY_B = 8'h92;
    localparam logic [7:0] PROT_ANS_B = 8'h15;

    // interrupt line idle high or held low
    typedef enum logic {
        IRQ_IDLE = 1'b0,
        IRQ_HOLD = 1'b1
    } irq_state_t;

endpackage

/* src/prot_irq_timer.sv */
// prot_irq_timer: controller interrupt held low for a set count after a main access
`timescale 1ns/1ns

module prot_irq_timer #(
    parameter int IRQ_HOLD = 255
) (
    input  logic clk,
    input  logic rst,
    input  logic set,
    output logic irqn
);
    import prot_game_pkg::*;

    localparam int CNT_W = $clog2(IRQ_HOLD + 1);

    irq_state_t       state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IRQ_IDLE;
            cnt   <= '0;
        end else if (set) begin
            // a new access restarts the full hold
            state <= prot_game_pkg::IRQ_HOLD;
            cnt   <= CNT_W'(IRQ_HOLD);
        end else begin
            case (state)
                IRQ_IDLE: begin
                    cnt <= '0;
                end
                default: begin
                    cnt <= cnt - 1'b1;
                    // release on the last count
                    if (cnt == CNT_W'(1)) begin
                        state <= IRQ_IDLE;
                    end
                end
            endcase
        end
    end

    assign irqn = (state == IRQ_IDLE);

endmodule

/* src/prot_local_ram.sv */
// prot_local_ram: controller work ram, single port with registered read
`timescale 1ns/1ns

module prot_local_ram #(
    parameter int LOCAL_AW = 11
) (
    input  logic                clk,
    input  logic [LOCAL_AW-1:0] addr,
    input  prot_bus_pkg::byte_t data,
    input  logic                we,
    output prot_bus_pkg::byte_t q
);
    import prot_bus_pkg::*;

    byte_t mem [2**LOCAL_AW];

    // read-before-write, q shows the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

/* src/prot_read_mux.sv */
// prot_read_mux: registered controller read data and wait line
`timescale 1ns/1ns

module prot_read_mux (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      main_cs,
    input  prot_bus_pkg::region_sel_t region,
    input  logic                      rom_cs,
    input  logic                      rom_ok,
    input  logic                      bac_cs,
    input  logic                      bac_ok,
    input  prot_bus_pkg::byte_t       ram_q,
    input  prot_bus_pkg::byte_t       shd_q,
    input  prot_bus_pkg::byte_t       answer,
    input  prot_bus_pkg::byte_t       bac_data,
    input  prot_bus_pkg::byte_t       bac_mode_din,
    input  prot_bus_pkg::byte_t       rom_data,
    output prot_bus_pkg::byte_t       mcu_din,
    output logic                      mcu_waitn
);
    import prot_bus_pkg::*;

    byte_t rd_sel;
    // ready flags, low while a request waits for its ok
    logic  rom_good;
    logic  bac_good;

    // fixed priority, open bus reads ff
    always_comb begin
        if (region.ram) begin
            rd_sel = ram_q;
        end else if (region.shd) begin
            rd_sel = shd_q;
        end else if (region.prot) begin
            rd_sel = answer;
        end else if (bac_cs) begin
            rd_sel = bac_data;
        end else if (region.bac_mode) begin
            rd_sel = bac_mode_din;
        end else if (rom_cs) begin
            rd_sel = rom_data;
        end else begin
            rd_sel = 8'hff;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcu_din  <= 8'hff;
            rom_good <= 1'b1;
            bac_good <= 1'b1;
        end else begin
            mcu_din  <= rd_sel;
            rom_good <= !rom_cs || rom_ok;
            bac_good <= !bac_cs || bac_ok;
        end
    end

    // main cpu owns the shared ram, controller stalls at once
    assign mcu_waitn = ~main_cs & rom_good & bac_good;

endmodule

/* src/prot_shared_ram.sv */
// dual-port ram between main cpu and controller
`timescale 1ns/1ns

module prot_shared_ram #(
    parameter int SHARED_AW = 13
) (
    input  logic                     clk,
    // main cpu side into the 2 kB window
    input  prot_bus_pkg::main_addr_t main_addr,
    input  prot_bus_pkg::byte_t      main_data,
    input  logic                     main_we,
    output prot_bus_pkg::byte_t      main_q,
    // controller side over the full depth
    input  logic [SHARED_AW-1:0]     mcu_addr,
    input  prot_bus_pkg::byte_t      mcu_data,
    input  logic                     mcu_we,
    output prot_bus_pkg::byte_t      mcu_q
);
    import prot_bus_pkg::*;

    byte_t                mem [2**SHARED_AW];
    logic [SHARED_AW-1:0] main_ext;

    // upper bits tied low so the main cpu only reaches the bottom 2 kB
    assign main_ext = SHARED_AW'(main_addr);

    // both ports on the one clock
    always_ff @(posedge clk) begin
        // main port
        if (main_we) begin
            mem[main_ext] <= main_data;
        end
        main_q <= mem[main_ext];
        // controller port
        if (mcu_we) begin
            mem[mcu_addr] <= mcu_data;
        end
        mcu_q <= mem[mcu_addr];
    end

endmodule

/* src/prot_top.sv */
// prot_top: protection board top, decode, rams, latch, interrupt timer and read mux
`timescale 1ns/1ns

module prot_top #(
    parameter int LOCAL_AW  = 11,
    parameter int SHARED_AW = 13,
    parameter int IRQ_HOLD  = 255
) (
    input  logic                     clk,
    input  logic                     rst,
    input  prot_game_pkg::game_id_t  game_id,
    // controller bus
    input  prot_bus_pkg::mcu_bus_t   mcu_bus,
    output prot_bus_pkg::byte_t      mcu_din,
    output logic                     mcu_waitn,
    output logic                     mcu_irqn,
    // main cpu side of the shared window
    input  prot_bus_pkg::main_addr_t main_addr,
    input  prot_bus_pkg::byte_t      main_dout,
    output prot_bus_pkg::byte_t      main_din,
    input  logic                     main_cs,
    input  logic                     main_wrn,
    // program rom
    output prot_bus_pkg::rom_addr_t  rom_addr,
    output logic                     rom_cs,
    input  prot_bus_pkg::byte_t      rom_data,
    input  logic                     rom_ok,
    // tile chip
    output prot_bus_pkg::bac_req_t   bac_req,
    input  prot_bus_pkg::byte_t      bac_data,
    input  prot_bus_pkg::byte_t      bac_mode_din,
    input  logic                     bac_ok
);
    import prot_bus_pkg::*;

    region_sel_t region;
    byte_t       ram_q;
    byte_t       shd_q;
    byte_t       answer;
    logic        ram_we;
    logic        shd_we;
    logic        main_we;
    logic        irq_set;

    assign rom_addr = mcu_bus.addr[15:0];
    assign rom_cs   = region.rom;
    assign ram_we   = region.ram & ~mcu_bus.wrn;
    assign shd_we   = region.shd & ~mcu_bus.wrn;
    assign main_we  = main_cs & ~main_wrn;
    // main touch of the last shared byte interrupts the controller
    assign irq_set  = main_cs && (main_addr == 11'h7ff);

    // decode
    prot_addr_decode u_decode (
        .game_id (game_id),
        .mcu_bus (mcu_bus),
        .region  (region),
        .bac_req (bac_req)
    );

    // execute
    prot_local_ram #(
        .LOCAL_AW (LOCAL_AW)
    ) u_local_ram (
        .clk  (clk),
        .addr (mcu_bus.addr[LOCAL_AW-1:0]),
        .data (mcu_bus.dout),
        .we   (ram_we),
        .q    (ram_q)
    );

    prot_shared_ram #(
        .SHARED_AW (SHARED_AW)
    ) u_shared_ram (
        .clk       (clk),
        .main_addr (main_addr),
        .main_data (main_dout),
        .main_we   (main_we),
        .main_q    (main_din),
        .mcu_addr  (mcu_bus.addr[SHARED_AW-1:0]),
        .mcu_data  (mcu_bus.dout),
        .mcu_we    (shd_we),
        .mcu_q     (shd_q)
    );

    prot_challenge u_challenge (
        .clk    (clk),
        .rst    (rst),
        .sel    (region.prot),
        .wrn    (mcu_bus.wrn),
        .data   (mcu_bus.dout),
        .answer (answer)
    );

    prot_irq_timer #(
        .IRQ_HOLD (IRQ_HOLD)
    ) u_irq_timer (
        .clk  (clk),
        .rst  (rst),
        .set  (irq_set),
        .irqn (mcu_irqn)
    );

    // result
    prot_read_mux u_read_mux (
        .clk          (clk),
        .rst          (rst),
        .main_cs      (main_cs),
        .region       (region),
        .rom_cs       (region.rom),
        .rom_ok       (rom_ok),
        .bac_cs       (bac_req.cs),
        .bac_ok       (bac_ok),
        .ram_q        (ram_q),
        .shd_q        (shd_q),
        .answer       (answer),
        .bac_data     (bac_data),
        .bac_mode_din (bac_mode_din),
        .rom_data     (rom_data),
        .mcu_din      (mcu_din),
        .mcu_waitn    (mcu_waitn)
    );

endmodule
